// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       := tb_id_stage
FILELIST  := sources.f
BUILD_DIR := obj_dir
LOG       := sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run $(TOP), check $(LOG) for the pass line"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q '^\*\*\* PASSED \*\*\*$$' $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: common/la_decode_pkg.sv
`default_nettype none

package la_decode_pkg;

  localparam int unsigned XLEN      = 32;
  localparam int unsigned REG_AW    = 5;
  localparam int unsigned CSR_NUM_W = 14;

  //////////////////////////////////////////////////////////////////////
  // instruction kinds handed from identification to control
  //////////////////////////////////////////////////////////////////////
  typedef enum logic [5:0] {
    INST_INVALID,
    // register-register alu
    INST_ADD_W, INST_SUB_W, INST_SLT, INST_SLTU, INST_NOR,
    INST_AND, INST_OR, INST_XOR, INST_SLL_W, INST_SRL_W, INST_SRA_W,
    // immediate forms
    INST_SLLI_W, INST_SRLI_W, INST_SRAI_W,
    INST_ADDI_W, INST_SLTI, INST_SLTUI, INST_ANDI, INST_ORI, INST_XORI,
    INST_LU12I_W, INST_PCADDU12I,
    // memory
    INST_LD_B, INST_LD_H, INST_LD_W, INST_LD_BU, INST_LD_HU,
    INST_ST_B, INST_ST_H, INST_ST_W,
    // control flow
    INST_JIRL, INST_B, INST_BL,
    INST_BEQ, INST_BNE, INST_BLT, INST_BGE, INST_BLTU, INST_BGEU,
    // csr and privileged
    INST_CSRRD, INST_CSRWR, INST_CSRXCHG,
    INST_SYSCALL, INST_BREAK, INST_ERTN
  } inst_kind_e;

  // gaps in the numbering are retired ops
  typedef enum logic [4:0] {
    ALU_NOP  = 5'd0,
    ALU_LUI  = 5'd1,
    ALU_ADD  = 5'd3,
    ALU_SUB  = 5'd4,
    ALU_BNE  = 5'd5,
    ALU_BLT  = 5'd6,
    ALU_BGE  = 5'd7,
    ALU_BLTU = 5'd8,
    ALU_BGEU = 5'd9,
    ALU_SLT  = 5'd10,
    ALU_SLTU = 5'd11,
    ALU_XOR  = 5'd12,
    ALU_OR   = 5'd13,
    ALU_AND  = 5'd14,
    ALU_SLL  = 5'd15,
    ALU_SRL  = 5'd16,
    ALU_SRA  = 5'd17,
    ALU_NOR  = 5'd18,
    ALU_BEQ  = 5'd19,
    ALU_CSR  = 5'd27
  } alu_op_e;

  typedef enum logic [4:0] {
    NPC_PLUS4  = 5'd0,
    NPC_BRANCH = 5'd1,
    NPC_B_BL   = 5'd6,
    NPC_ERTN   = 5'd8,
    NPC_JIRL   = 5'd24
  } npc_op_e;

  typedef enum logic [1:0] {
    WD_ALU = 2'd0,
    WD_MEM = 2'd1,
    WD_PC  = 2'd2  // link address
  } wd_sel_e;

  typedef enum logic [2:0] {
    DM_WORD   = 3'd0,
    DM_HALF   = 3'd1,
    DM_HALF_U = 3'd2,
    DM_BYTE   = 3'd3,
    DM_BYTE_U = 3'd4
  } dm_type_e;

  //////////////////////////////////////////////////////////////////////
  // packets
  //////////////////////////////////////////////////////////////////////
  typedef struct packed {
    logic [XLEN-1:0] pc;
    logic [XLEN-1:0] inst;
  } fetch_pkt_t;

  typedef struct packed {
    logic     reg_write;
    logic     mem_write;
    logic     mem_read;
    logic     src1_is_pc;
    logic     src2_is_imm;
    wd_sel_e  wd_sel;
    alu_op_e  alu_op;
    npc_op_e  npc_op;
    dm_type_e dm_type;
  } ctrl_t;

  typedef struct packed {
    logic [CSR_NUM_W-1:0] csr_num;
    logic                 csr_write;
    logic                 csr_mask_en;  // csrxchg writes under rj mask
  } csr_t;

  typedef struct packed {
    logic ine;
    logic sys;
    logic brk;
    logic ertn;
  } excp_t;

  typedef struct packed {
    logic [XLEN-1:0]   pc;
    ctrl_t             ctrl;
    logic [REG_AW-1:0] rd;
    logic [REG_AW-1:0] rs1;
    logic [REG_AW-1:0] rs2;
    logic [XLEN-1:0]   imm4alu;
    logic [XLEN-1:0]   imm4pc;
    csr_t              csr;
    excp_t             excp;
  } dec_pkt_t;

endpackage

`default_nettype wire

// File: decode/ctrl_gen.sv
`timescale 1ns/10ps
`default_nettype none

module ctrl_gen import la_decode_pkg::*; (
  input  logic [XLEN-1:0]   i_inst,
  input  inst_kind_e        i_kind,
  output ctrl_t             o_ctrl,
  output logic [REG_AW-1:0] o_rd,
  output logic [REG_AW-1:0] o_rs1,
  output logic [REG_AW-1:0] o_rs2,
  output csr_t              o_csr,
  output excp_t             o_excp
);

  logic is_load, is_store, is_cond_br, src_reg_is_rd;

  assign is_load    = i_kind inside {INST_LD_B, INST_LD_H, INST_LD_W, INST_LD_BU, INST_LD_HU};
  assign is_store   = i_kind inside {INST_ST_B, INST_ST_H, INST_ST_W};
  assign is_cond_br = i_kind inside {INST_BEQ, INST_BNE, INST_BLT,
                                     INST_BGE, INST_BLTU, INST_BGEU};
  // second read port takes rd when rd is a source
  assign src_reg_is_rd = is_cond_br | is_store | (i_kind inside {INST_CSRWR, INST_CSRXCHG});

  ////////////////////////////////////////////////////////////////////////
  // control bundle
  ////////////////////////////////////////////////////////////////////////
  always_comb begin
    o_ctrl.reg_write   = ~(is_store | is_cond_br | (i_kind == INST_B));
    o_ctrl.mem_write   = is_store;
    o_ctrl.mem_read    = is_load;
    o_ctrl.src1_is_pc  = i_kind inside {INST_JIRL, INST_BL, INST_PCADDU12I};
    o_ctrl.src2_is_imm = is_load | is_store |
                         (i_kind inside {INST_SLLI_W, INST_SRLI_W, INST_SRAI_W, INST_ADDI_W,
                                         INST_SLTI, INST_SLTUI, INST_ANDI, INST_ORI,
                                         INST_XORI, INST_LU12I_W, INST_PCADDU12I,
                                         INST_JIRL, INST_BL});
    o_ctrl.wd_sel = is_load                                ? WD_MEM :
                    (i_kind inside {INST_JIRL, INST_BL})   ? WD_PC  :
                                                             WD_ALU;

    case (i_kind)
      INST_ADD_W, INST_ADDI_W, INST_PCADDU12I,
      INST_JIRL, INST_B, INST_BL,
      INST_LD_B, INST_LD_H, INST_LD_W, INST_LD_BU, INST_LD_HU,
      INST_ST_B, INST_ST_H, INST_ST_W:        o_ctrl.alu_op = ALU_ADD;  // address or link
      INST_SUB_W:                             o_ctrl.alu_op = ALU_SUB;
      INST_SLT, INST_SLTI:                    o_ctrl.alu_op = ALU_SLT;
      INST_SLTU, INST_SLTUI:                  o_ctrl.alu_op = ALU_SLTU;
      INST_NOR:                               o_ctrl.alu_op = ALU_NOR;
      INST_AND, INST_ANDI:                    o_ctrl.alu_op = ALU_AND;
      INST_OR, INST_ORI:                      o_ctrl.alu_op = ALU_OR;
      INST_XOR, INST_XORI:                    o_ctrl.alu_op = ALU_XOR;
      INST_SLL_W, INST_SLLI_W:                o_ctrl.alu_op = ALU_SLL;
      INST_SRL_W, INST_SRLI_W:                o_ctrl.alu_op = ALU_SRL;
      INST_SRA_W, INST_SRAI_W:                o_ctrl.alu_op = ALU_SRA;
      INST_LU12I_W:                           o_ctrl.alu_op = ALU_LUI;
      INST_BEQ:                               o_ctrl.alu_op = ALU_BEQ;
      INST_BNE:                               o_ctrl.alu_op = ALU_BNE;
      INST_BLT:                               o_ctrl.alu_op = ALU_BLT;
      INST_BGE:                               o_ctrl.alu_op = ALU_BGE;
      INST_BLTU:                              o_ctrl.alu_op = ALU_BLTU;
      INST_BGEU:                              o_ctrl.alu_op = ALU_BGEU;
      INST_CSRRD, INST_CSRWR, INST_CSRXCHG:   o_ctrl.alu_op = ALU_CSR;
      default:                                o_ctrl.alu_op = ALU_NOP;
    endcase

    o_ctrl.npc_op = is_cond_br                         ? NPC_BRANCH :
                    (i_kind inside {INST_B, INST_BL})  ? NPC_B_BL   :
                    (i_kind == INST_JIRL)              ? NPC_JIRL   :
                    (i_kind == INST_ERTN)              ? NPC_ERTN   :
                                                         NPC_PLUS4;

    case (i_kind)
      INST_LD_B, INST_ST_B: o_ctrl.dm_type = DM_BYTE;
      INST_LD_H, INST_ST_H: o_ctrl.dm_type = DM_HALF;
      INST_LD_HU:           o_ctrl.dm_type = DM_HALF_U;
      INST_LD_BU:           o_ctrl.dm_type = DM_BYTE_U;
      default:              o_ctrl.dm_type = DM_WORD;
    endcase
  end

  // register addresses
  assign o_rd  = (i_kind == INST_BL) ? REG_AW'(1) : i_inst[4:0];  // bl links into r1
  assign o_rs1 = i_inst[9:5];
  assign o_rs2 = src_reg_is_rd ? i_inst[4:0] : i_inst[14:10];

  assign o_csr = '{csr_num:     i_inst[23:10],
                   csr_write:   i_kind inside {INST_CSRWR, INST_CSRXCHG},
                   csr_mask_en: i_kind == INST_CSRXCHG};

  assign o_excp = '{ine:  i_kind == INST_INVALID,
                    sys:  i_kind == INST_SYSCALL,
                    brk:  i_kind == INST_BREAK,
                    ertn: i_kind == INST_ERTN};

endmodule

`default_nettype wire

// File: decode/imm_gen.sv
`timescale 1ns/10ps
`default_nettype none

module imm_gen import la_decode_pkg::*; (
  input  logic [XLEN-1:0] i_inst,
  input  inst_kind_e      i_kind,
  output logic [XLEN-1:0] o_imm4alu,
  output logic [XLEN-1:0] o_imm4pc
);

  logic [4:0]      ui5;
  logic [11:0]     i12;
  logic [15:0]     i16;
  logic [19:0]     i20;
  logic [25:0]     i26;
  logic [XLEN-1:0] offs16;
  logic [XLEN-1:0] offs26;
  logic need_ui5, need_ui12, need_si16, need_si20, need_si26, src2_is_4;

  assign ui5 = i_inst[14:10];
  assign i12 = i_inst[21:10];
  assign i16 = i_inst[25:10];
  assign i20 = i_inst[24:5];
  assign i26 = {i_inst[9:0], i_inst[25:10]};  // offs[25:16] sits low in the word

  // word offsets, scaled by 4
  assign offs16 = {{(XLEN-18){i16[15]}}, i16, 2'b00};
  assign offs26 = {{(XLEN-28){i26[25]}}, i26, 2'b00};

  assign need_ui5  = i_kind inside {INST_SLLI_W, INST_SRLI_W, INST_SRAI_W};
  assign need_ui12 = i_kind inside {INST_ANDI, INST_ORI, INST_XORI};
  assign need_si16 = i_kind inside {INST_JIRL, INST_BEQ, INST_BNE, INST_BLT,
                                    INST_BGE, INST_BLTU, INST_BGEU};
  assign need_si20 = i_kind inside {INST_LU12I_W, INST_PCADDU12I};
  assign need_si26 = i_kind inside {INST_B, INST_BL};
  assign src2_is_4 = i_kind inside {INST_JIRL, INST_BL};  // link = pc + 4

  assign o_imm4alu = src2_is_4 ? XLEN'(4)                          :
                     need_si20 ? {i20, {(XLEN-20){1'b0}}}          :
                     need_si16 ? offs16                            :
                     need_si26 ? offs26                            :
                     need_ui5  ? {{(XLEN-5){1'b0}}, ui5}           :
                     need_ui12 ? {{(XLEN-12){1'b0}}, i12}          :
                                 {{(XLEN-12){i12[11]}}, i12};      // si12

  assign o_imm4pc = need_si26 ? offs26 :
                    need_si16 ? offs16 :
                                '0;

endmodule

`default_nettype wire

// File: decode/inst_identify.sv
`timescale 1ns/10ps
`default_nettype none

module inst_identify import la_decode_pkg::*; (
  input  logic [XLEN-1:0] i_inst,
  output inst_kind_e      o_kind
);

  logic [5:0] op_31_26;
  logic [3:0] op_25_22;
  logic [1:0] op_21_20;
  logic [4:0] op_19_15;
  logic [4:0] rj;

  assign op_31_26 = i_inst[31:26];
  assign op_25_22 = i_inst[25:22];
  assign op_21_20 = i_inst[21:20];
  assign op_19_15 = i_inst[19:15];
  assign rj       = i_inst[9:5];

  always_comb begin
    o_kind = INST_INVALID;  // anything unmatched raises ine later
    case (op_31_26)
      6'h00: begin
        case (op_25_22)
          4'h0: begin
            if (op_21_20 == 2'h1) begin
              case (op_19_15)
                5'h00: o_kind = INST_ADD_W;
                5'h02: o_kind = INST_SUB_W;
                5'h04: o_kind = INST_SLT;
                5'h05: o_kind = INST_SLTU;
                5'h08: o_kind = INST_NOR;
                5'h09: o_kind = INST_AND;
                5'h0a: o_kind = INST_OR;
                5'h0b: o_kind = INST_XOR;
                5'h0e: o_kind = INST_SLL_W;
                5'h0f: o_kind = INST_SRL_W;
                5'h10: o_kind = INST_SRA_W;
                default: ;
              endcase
            end else if (op_21_20 == 2'h2) begin
              if (op_19_15 == 5'h14) o_kind = INST_BREAK;
              if (op_19_15 == 5'h16) o_kind = INST_SYSCALL;
            end
          end
          4'h1: begin
            if (op_21_20 == 2'h0) begin
              case (op_19_15)
                5'h01: o_kind = INST_SLLI_W;
                5'h09: o_kind = INST_SRLI_W;
                5'h11: o_kind = INST_SRAI_W;
                default: ;
              endcase
            end
          end
          4'h8: o_kind = INST_SLTI;
          4'h9: o_kind = INST_SLTUI;
          4'ha: o_kind = INST_ADDI_W;
          4'hd: o_kind = INST_ANDI;
          4'he: o_kind = INST_ORI;
          4'hf: o_kind = INST_XORI;
          default: ;
        endcase
      end
      6'h01: begin
        if (i_inst[25:24] == 2'b00) begin  // csr group where rj picks the op
          if (rj == 5'd0)      o_kind = INST_CSRRD;
          else if (rj == 5'd1) o_kind = INST_CSRWR;
          else                 o_kind = INST_CSRXCHG;
        end else if (op_25_22 == 4'h9 && op_21_20 == 2'h0 && op_19_15 == 5'h10
                     && i_inst[14:10] == 5'h0e) begin
          o_kind = INST_ERTN;
        end
      end
      6'h05: if (!i_inst[25]) o_kind = INST_LU12I_W;
      6'h07: if (!i_inst[25]) o_kind = INST_PCADDU12I;
      6'h0a: begin
        case (op_25_22)
          4'h0: o_kind = INST_LD_B;
          4'h1: o_kind = INST_LD_H;
          4'h2: o_kind = INST_LD_W;
          4'h4: o_kind = INST_ST_B;
          4'h5: o_kind = INST_ST_H;
          4'h6: o_kind = INST_ST_W;
          4'h8: o_kind = INST_LD_BU;
          4'h9: o_kind = INST_LD_HU;
          default: ;
        endcase
      end
      6'h13: o_kind = INST_JIRL;
      6'h14: o_kind = INST_B;
      6'h15: o_kind = INST_BL;
      6'h16: o_kind = INST_BEQ;
      6'h17: o_kind = INST_BNE;
      6'h18: o_kind = INST_BLT;
      6'h19: o_kind = INST_BGE;
      6'h1a: o_kind = INST_BLTU;
      6'h1b: o_kind = INST_BGEU;
      default: ;
    endcase
  end

endmodule

`default_nettype wire

// File: source/id_stage.sv
`timescale 1ns/10ps
`default_nettype none

module id_stage import la_decode_pkg::*; (
  input  logic       i_clk,
  input  logic       i_rst_n,
  input  fetch_pkt_t i_fetch,
  input  logic       i_fetch_valid,
  input  logic       i_dec_ready,
  output logic       o_fetch_ready,
  output dec_pkt_t   o_dec,
  output logic       o_dec_valid
);

  fetch_pkt_t        fetch_q;
  logic              fetch_q_valid;
  logic              dec_in_ready;   // back-pressure from output register
  inst_kind_e        kind;
  ctrl_t             ctrl;
  logic [REG_AW-1:0] rd, rs1, rs2;
  logic [XLEN-1:0]   imm4alu, imm4pc;
  csr_t              csr;
  excp_t             excp;
  dec_pkt_t          dec_d;

  pipe_reg #(.payload_t(fetch_pkt_t)) u_fetch_reg (
    .i_clk, .i_rst_n,
    .i_valid (i_fetch_valid), .i_data (i_fetch), .i_ready (dec_in_ready),
    .o_ready (o_fetch_ready), .o_valid (fetch_q_valid), .o_data (fetch_q)
  );

  ////////////////////////////////////////////////////////////////////////
  // combinational decode between the two registers
  ////////////////////////////////////////////////////////////////////////
  inst_identify u_identify (.i_inst (fetch_q.inst), .o_kind (kind));

  imm_gen u_imm (
    .i_inst (fetch_q.inst), .i_kind (kind), .o_imm4alu (imm4alu), .o_imm4pc (imm4pc)
  );

  ctrl_gen u_ctrl (
    .i_inst (fetch_q.inst), .i_kind (kind), .o_ctrl (ctrl),
    .o_rd (rd), .o_rs1 (rs1), .o_rs2 (rs2), .o_csr (csr), .o_excp (excp)
  );

  assign dec_d = '{pc: fetch_q.pc, ctrl: ctrl, rd: rd, rs1: rs1, rs2: rs2,
                   imm4alu: imm4alu, imm4pc: imm4pc, csr: csr, excp: excp};

  pipe_reg #(.payload_t(dec_pkt_t)) u_dec_reg (
    .i_clk, .i_rst_n,
    .i_valid (fetch_q_valid), .i_data (dec_d), .i_ready (i_dec_ready),
    .o_ready (dec_in_ready), .o_valid (o_dec_valid), .o_data (o_dec)
  );

endmodule

`default_nettype wire

// File: source/pipe_reg.sv
`timescale 1ns/10ps
`default_nettype none

module pipe_reg #(
  parameter type payload_t = logic
) (
  input  logic     i_clk,
  input  logic     i_rst_n,
  input  logic     i_valid,
  input  payload_t i_data,
  input  logic     i_ready,
  output logic     o_ready,
  output logic     o_valid,
  output payload_t o_data
);

  logic     valid_q;
  payload_t data_q;
  logic     load;

  // free slot or the held item leaves this edge
  assign o_ready = ~valid_q | i_ready;
  assign load    = i_valid & o_ready;

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      valid_q <= 1'b0;
    end else if (o_ready) begin
      valid_q <= i_valid;  // refill or drain
    end
  end

  always_ff @(posedge i_clk) begin
    if (load) begin
      data_q <= i_data;
    end
  end

  assign o_valid = valid_q;
  assign o_data  = data_q;

endmodule

`default_nettype wire

// File: sources.f
common/la_decode_pkg.sv
source/pipe_reg.sv
decode/inst_identify.sv
decode/imm_gen.sv
decode/ctrl_gen.sv
source/id_stage.sv
tests/tb_id_stage.sv

// File: tests/tb_id_stage.sv
`timescale 1ns/10ps
`default_nettype none

module tb_id_stage import la_decode_pkg::*; ();

  localparam logic [31:0] SEED     = 32'h711179dc;
  localparam int          TIMEOUT  = 200;  // cycles per wait
  localparam int          N_RANDOM = 400;

  // instruction classes of the reference encoding table
  typedef enum logic [3:0] {
    C_RR, C_RI, C_PCADD, C_LD, C_ST, C_BR, C_JIRL, C_B, C_BL,
    C_CSRRD, C_CSRWR, C_CSRXCHG, C_SYS, C_BRK, C_ERTN, C_NONE
  } cls_e;

  typedef enum logic [2:0] {IM_S12, IM_U12, IM_U5, IM_S20, IM_S16, IM_S26} imm_e;

  typedef struct packed {
    logic [31:0] mask;
    logic [31:0] match;
    cls_e        cls;
    imm_e        imm;
    logic [4:0]  alu;
    logic [2:0]  dm;
  } enc_t;

  logic       i_clk;
  logic       i_rst_n;
  fetch_pkt_t i_fetch;
  logic       i_fetch_valid;
  logic       i_dec_ready;
  logic       o_fetch_ready;
  dec_pkt_t   o_dec;
  logic       o_dec_valid;

  enc_t        enc_q [$];
  fetch_pkt_t  pend_q [$];  // accepted, not yet delivered
  int          edge_cnt;
  int          acc_edge;
  int          n_checked;
  int          n_value_err;
  int          n_other_err;
  int          n_timeout;
  logic        bp_on;
  logic        gaps_on;
  logic [31:0] pc_next;

  id_stage dut0 (.*);

  always #10 i_clk = ~i_clk;

  always @(posedge i_clk) begin
    edge_cnt <= edge_cnt + 1;
  end

  // random back-pressure from downstream
  always @(posedge i_clk) begin
    #1;
    i_dec_ready = bp_on ? ($urandom_range(0, 3) != 0) : 1'b1;
  end

  ////////////////////////////////////////////////////////////////////////
  // reference encoding table and decode
  ////////////////////////////////////////////////////////////////////////
  task automatic add_enc(input logic [31:0] mask, input logic [31:0] match, input cls_e cls,
                         input imm_e imm, input logic [4:0] alu, input logic [2:0] dm);
    enc_q.push_back('{mask: mask, match: match, cls: cls, imm: imm, alu: alu, dm: dm});
  endtask

  task automatic build_table();
    add_enc(32'hffff8000, 32'h00100000, C_RR, IM_S12, 5'd3, 3'd0);    // add.w
    add_enc(32'hffff8000, 32'h00110000, C_RR, IM_S12, 5'd4, 3'd0);    // sub.w
    add_enc(32'hffff8000, 32'h00120000, C_RR, IM_S12, 5'd10, 3'd0);   // slt
    add_enc(32'hffff8000, 32'h00128000, C_RR, IM_S12, 5'd11, 3'd0);   // sltu
    add_enc(32'hffff8000, 32'h00140000, C_RR, IM_S12, 5'd18, 3'd0);   // nor
    add_enc(32'hffff8000, 32'h00148000, C_RR, IM_S12, 5'd14, 3'd0);   // and
    add_enc(32'hffff8000, 32'h00150000, C_RR, IM_S12, 5'd13, 3'd0);   // or
    add_enc(32'hffff8000, 32'h00158000, C_RR, IM_S12, 5'd12, 3'd0);   // xor
    add_enc(32'hffff8000, 32'h00170000, C_RR, IM_S12, 5'd15, 3'd0);   // sll.w
    add_enc(32'hffff8000, 32'h00178000, C_RR, IM_S12, 5'd16, 3'd0);   // srl.w
    add_enc(32'hffff8000, 32'h00180000, C_RR, IM_S12, 5'd17, 3'd0);   // sra.w
    add_enc(32'hffff8000, 32'h00408000, C_RI, IM_U5, 5'd15, 3'd0);    // slli.w
    add_enc(32'hffff8000, 32'h00448000, C_RI, IM_U5, 5'd16, 3'd0);    // srli.w
    add_enc(32'hffff8000, 32'h00488000, C_RI, IM_U5, 5'd17, 3'd0);    // srai.w
    add_enc(32'hffc00000, 32'h02000000, C_RI, IM_S12, 5'd10, 3'd0);   // slti
    add_enc(32'hffc00000, 32'h02400000, C_RI, IM_S12, 5'd11, 3'd0);   // sltui
    add_enc(32'hffc00000, 32'h02800000, C_RI, IM_S12, 5'd3, 3'd0);    // addi.w
    add_enc(32'hffc00000, 32'h03400000, C_RI, IM_U12, 5'd14, 3'd0);   // andi
    add_enc(32'hffc00000, 32'h03800000, C_RI, IM_U12, 5'd13, 3'd0);   // ori
    add_enc(32'hffc00000, 32'h03c00000, C_RI, IM_U12, 5'd12, 3'd0);   // xori
    add_enc(32'hfe000000, 32'h14000000, C_RI, IM_S20, 5'd1, 3'd0);    // lu12i.w
    add_enc(32'hfe000000, 32'h1c000000, C_PCADD, IM_S20, 5'd3, 3'd0); // pcaddu12i
    add_enc(32'hffc00000, 32'h28000000, C_LD, IM_S12, 5'd3, 3'd3);    // ld.b
    add_enc(32'hffc00000, 32'h28400000, C_LD, IM_S12, 5'd3, 3'd1);    // ld.h
    add_enc(32'hffc00000, 32'h28800000, C_LD, IM_S12, 5'd3, 3'd0);    // ld.w
    add_enc(32'hffc00000, 32'h29000000, C_ST, IM_S12, 5'd3, 3'd3);    // st.b
    add_enc(32'hffc00000, 32'h29400000, C_ST, IM_S12, 5'd3, 3'd1);    // st.h
    add_enc(32'hffc00000, 32'h29800000, C_ST, IM_S12, 5'd3, 3'd0);    // st.w
    add_enc(32'hffc00000, 32'h2a000000, C_LD, IM_S12, 5'd3, 3'd4);    // ld.bu
    add_enc(32'hffc00000, 32'h2a400000, C_LD, IM_S12, 5'd3, 3'd2);    // ld.hu
    add_enc(32'hfc000000, 32'h4c000000, C_JIRL, IM_S16, 5'd3, 3'd0);  // jirl
    add_enc(32'hfc000000, 32'h50000000, C_B, IM_S26, 5'd3, 3'd0);     // b
    add_enc(32'hfc000000, 32'h54000000, C_BL, IM_S26, 5'd3, 3'd0);    // bl
    add_enc(32'hfc000000, 32'h58000000, C_BR, IM_S16, 5'd19, 3'd0);   // beq
    add_enc(32'hfc000000, 32'h5c000000, C_BR, IM_S16, 5'd5, 3'd0);    // bne
    add_enc(32'hfc000000, 32'h60000000, C_BR, IM_S16, 5'd6, 3'd0);    // blt
    add_enc(32'hfc000000, 32'h64000000, C_BR, IM_S16, 5'd7, 3'd0);    // bge
    add_enc(32'hfc000000, 32'h68000000, C_BR, IM_S16, 5'd8, 3'd0);    // bltu
    add_enc(32'hfc000000, 32'h6c000000, C_BR, IM_S16, 5'd9, 3'd0);    // bgeu
    // csr rj of 0 and 1 come before the catch-all
    add_enc(32'hff0003e0, 32'h04000000, C_CSRRD, IM_S12, 5'd27, 3'd0);
    add_enc(32'hff0003e0, 32'h04000020, C_CSRWR, IM_S12, 5'd27, 3'd0);
    add_enc(32'hff000000, 32'h04000000, C_CSRXCHG, IM_S12, 5'd27, 3'd0);
    add_enc(32'hffff8000, 32'h002b0000, C_SYS, IM_S12, 5'd0, 3'd0);   // syscall
    add_enc(32'hffff8000, 32'h002a0000, C_BRK, IM_S12, 5'd0, 3'd0);   // break
    add_enc(32'hfffffc00, 32'h06483800, C_ERTN, IM_S12, 5'd0, 3'd0);  // ertn
  endtask

  function automatic logic [31:0] encode_random(input enc_t e);
    return ($urandom() & ~e.mask) | e.match;
  endfunction

  function automatic dec_pkt_t ref_decode(input fetch_pkt_t f);
    enc_t        e;
    int          i;
    logic [31:0] w;
    logic [31:0] si16;
    logic [31:0] si26;
    logic [31:0] imm_alu;
    logic [31:0] imm_pc;
    logic [4:0]  npc;
    logic [1:0]  wd;
    logic        mem_rd;
    w = f.inst;
    e = '{mask: '0, match: '0, cls: C_NONE, imm: IM_S12, alu: 5'd0, dm: 3'd0};
    for (i = enc_q.size() - 1; i >= 0; i--) begin
      if ((w & enc_q[i].mask) == enc_q[i].match) e = enc_q[i];  // earliest entry wins
    end
    si16 = {{14{w[25]}}, w[25:10], 2'b00};
    si26 = {{4{w[9]}}, w[9:0], w[25:10], 2'b00};
    case (e.imm)
      IM_S20:  imm_alu = {w[24:5], 12'h000};
      IM_S16:  imm_alu = si16;
      IM_S26:  imm_alu = si26;
      IM_U5:   imm_alu = {27'd0, w[14:10]};
      IM_U12:  imm_alu = {20'd0, w[21:10]};
      default: imm_alu = {{20{w[21]}}, w[21:10]};
    endcase
    if (e.cls inside {C_JIRL, C_BL}) imm_alu = 32'd4;  // pc + 4 link
    imm_pc = (e.imm == IM_S26) ? si26 : (e.imm == IM_S16) ? si16 : 32'd0;
    case (e.cls)
      C_BR:      npc = 5'd1;
      C_B, C_BL: npc = 5'd6;
      C_JIRL:    npc = 5'd24;
      C_ERTN:    npc = 5'd8;
      default:   npc = 5'd0;
    endcase
    mem_rd = (e.cls == C_LD);
    wd     = mem_rd ? 2'd1 : (e.cls inside {C_JIRL, C_BL}) ? 2'd2 : 2'd0;
    return {f.pc,
            !(e.cls inside {C_ST, C_BR, C_B}), e.cls == C_ST, mem_rd,
            e.cls inside {C_PCADD, C_JIRL, C_BL},
            e.cls inside {C_RI, C_PCADD, C_LD, C_ST, C_JIRL, C_BL},
            wd, e.alu, npc, e.dm,
            (e.cls == C_BL) ? 5'd1 : w[4:0], w[9:5],
            (e.cls inside {C_BR, C_ST, C_CSRWR, C_CSRXCHG}) ? w[4:0] : w[14:10],
            imm_alu, imm_pc,
            w[23:10], e.cls inside {C_CSRWR, C_CSRXCHG}, e.cls == C_CSRXCHG,
            e.cls == C_NONE, e.cls == C_SYS, e.cls == C_BRK, e.cls == C_ERTN};
  endfunction

  ////////////////////////////////////////////////////////////////////////
  // acceptance tracking and comparison at mid-cycle
  ////////////////////////////////////////////////////////////////////////
  task automatic check_field(input string name, input logic [63:0] got,
                             input logic [63:0] want, input logic [31:0] inst);
    assert (got === want) else begin
      n_value_err++;
      $display("FAIL %s got %h exp %h inst %h", name, got, want, inst);
    end
  endtask

  always @(negedge i_clk) begin
    fetch_pkt_t f;
    dec_pkt_t   want;
    if (i_rst_n) begin
      assert (o_fetch_ready || pend_q.size() == 2) else begin
        n_other_err++;
        $display("o_fetch_ready low with fewer than two packets in flight");
      end
      if (o_dec_valid && i_dec_ready) begin
        if (pend_q.size() == 0) begin
          n_other_err++;
          $display("decoded packet delivered with nothing pending");
        end else begin
          f    = pend_q.pop_front();
          want = ref_decode(f);
          n_checked++;
          check_field("o_dec.pc", 64'(o_dec.pc), 64'(want.pc), f.inst);
          check_field("o_dec.ctrl", 64'(o_dec.ctrl), 64'(want.ctrl), f.inst);
          check_field("o_dec.rd_rs1_rs2", 64'({o_dec.rd, o_dec.rs1, o_dec.rs2}),
                      64'({want.rd, want.rs1, want.rs2}), f.inst);
          check_field("o_dec.imm4alu", 64'(o_dec.imm4alu), 64'(want.imm4alu), f.inst);
          check_field("o_dec.imm4pc", 64'(o_dec.imm4pc), 64'(want.imm4pc), f.inst);
          check_field("o_dec.csr", 64'(o_dec.csr), 64'(want.csr), f.inst);
          check_field("o_dec.excp", 64'(o_dec.excp), 64'(want.excp), f.inst);
        end
      end
      if (i_fetch_valid && o_fetch_ready) begin
        pend_q.push_back(i_fetch);
        acc_edge = edge_cnt + 1;  // transfer happens on the coming edge
      end
    end
  end

  // starts 1 ns after a rising edge and returns at that point after acceptance
  task automatic send_fetch(input logic [31:0] inst);
    int waited;
    i_fetch       = '{pc: pc_next, inst: inst};
    i_fetch_valid = 1'b1;
    pc_next       = pc_next + 32'd4;
    waited        = 0;
    @(negedge i_clk);
    while (!o_fetch_ready && waited < TIMEOUT) begin
      @(negedge i_clk);
      waited++;
    end
    if (!o_fetch_ready) begin
      n_timeout++;
      $display("timeout waiting for o_fetch_ready, inst %h", inst);
    end
    @(posedge i_clk);
    #1;
    i_fetch_valid = 1'b0;
    if (gaps_on) begin
      repeat ($urandom_range(0, 2)) begin
        @(posedge i_clk);
        #1;
      end
    end
  endtask

  ////////////////////////////////////////////////////////////////////////
  // main sequence
  ////////////////////////////////////////////////////////////////////////
  initial begin
    int          waited;
    int          k;
    int          idx;
    logic [31:0] w;
    void'($urandom(SEED));
    i_clk         = 1'b0;
    i_rst_n       = 1'b0;
    i_fetch       = '0;
    i_fetch_valid = 1'b0;
    i_dec_ready   = 1'b1;
    bp_on         = 1'b0;
    gaps_on       = 1'b0;
    pc_next       = 32'h1c000000;
    edge_cnt      = 0;
    acc_edge      = 0;
    n_checked     = 0;
    n_value_err   = 0;
    n_other_err   = 0;
    n_timeout     = 0;
    build_table();
    repeat (4) @(posedge i_clk);
    #1;
    i_rst_n = 1'b1;
    @(negedge i_clk);
    assert (!o_dec_valid && o_fetch_ready) else begin
      n_other_err++;
      $display("handshake outputs wrong after reset");
    end
    @(posedge i_clk);
    #1;

    // single packet into an empty pipe
    send_fetch(32'h00100000 | ($urandom() & 32'h00007fff));
    waited = 0;
    @(negedge i_clk);
    while (!o_dec_valid && waited < TIMEOUT) begin
      @(negedge i_clk);
      waited++;
    end
    assert (o_dec_valid && edge_cnt == acc_edge + 1) else begin
      n_other_err++;
      $display("first packet did not reach the output one edge after acceptance");
    end
    @(posedge i_clk);
    #1;

    for (k = 0; k < enc_q.size() * 6; k++) begin
      send_fetch(encode_random(enc_q[k % enc_q.size()]));
    end
    repeat (40) send_fetch($urandom() | 32'hc0000000);  // opcode space with no encoding

    bp_on   = 1'b1;
    gaps_on = 1'b1;
    repeat (N_RANDOM) begin
      if ($urandom_range(0, 5) == 0) begin
        w = $urandom();
      end else begin
        idx = $urandom_range(0, enc_q.size() - 1);
        w   = encode_random(enc_q[idx]);
      end
      send_fetch(w);
    end
    bp_on = 1'b0;

    waited = 0;
    while (pend_q.size() != 0 && waited < TIMEOUT) begin
      @(negedge i_clk);
      waited++;
    end
    if (pend_q.size() != 0) begin
      n_timeout++;
      $display("timeout with %0d packets still inside the decoder", pend_q.size());
    end

    $display("checked %0d packets: %0d value errors, %0d protocol errors, %0d timeouts",
             n_checked, n_value_err, n_other_err, n_timeout);
    if (n_value_err + n_other_err + n_timeout == 0 && n_checked > 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

`default_nettype wire
